// ==== hdl/rp_analog_pkg.sv ====
package rp_analog_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int SAMPLE_W   = 14;  // Converted sample and DAC code
  localparam int ADC_WORD_W = 16;  // Raw word at the ADC pins
  localparam int ADC_PAD_W  = 2;   // Reserved low bits of a 16 bit ADC

  // Default moving average window
  localparam int AVG_DEPTH_DEF = 64;

  //////////////////////////////
  // Sample types
  //////////////////////////////

  // Two's complement sample, used everywhere inside the data path
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Offset code with negative slope, as the DAC wants it
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  //////////////////////////////
  // ADC pin word
  //////////////////////////////

  // Code field sits above the reserved bits
  typedef struct packed {
    logic [SAMPLE_W-1:0]  code;  // Unsigned code, negative slope
    logic [ADC_PAD_W-1:0] pad;   // Reserved, always ignored
  } adc_field_t;

  // Same 16 bits, seen raw or split into fields
  typedef union packed {
    logic [ADC_WORD_W-1:0] raw;  // Capture view
    adc_field_t            fld;  // Conversion view
  } adc_word_u;

  // Field layout must cover the whole pin word
  localparam bit ADC_LAYOUT_OK = (SAMPLE_W + ADC_PAD_W) == ADC_WORD_W;

endpackage : rp_analog_pkg

// ==== hdl/adc_frontend.sv ====
`timescale 1ns/1ps

module adc_frontend (
  input  logic                    adc_clk,
  input  logic                    adc_rstn,
  input  rp_analog_pkg::adc_word_u adc_dat_a_i,  // Raw pins, channel A
  input  rp_analog_pkg::adc_word_u adc_dat_b_i,  // Raw pins, channel B
  input  logic                    loop_i,       // Digital loopback enable
  input  rp_analog_pkg::sample_t   loop_a_i,     // Saturated mix A
  input  rp_analog_pkg::sample_t   loop_b_i,     // Saturated mix B
  output rp_analog_pkg::sample_t   adc_a_o,
  output rp_analog_pkg::sample_t   adc_b_o
);

  localparam int SW = rp_analog_pkg::SAMPLE_W;

  rp_analog_pkg::adc_word_u raw_a_q;  // Input register A
  rp_analog_pkg::adc_word_u raw_b_q;  // Input register B
  rp_analog_pkg::sample_t   conv_a;
  rp_analog_pkg::sample_t   conv_b;

  // Negative slope unsigned code to two's complement
  // Top bit stays, the rest flips
  function automatic rp_analog_pkg::sample_t code_to_sample(input logic [SW-1:0] code);
    return {code[SW-1], ~code[SW-2:0]};
  endfunction

  //////////////////////////////
  // Capture
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q.raw <= '0;
      raw_b_q.raw <= '0;
    end else begin
      raw_a_q.raw <= adc_dat_a_i.raw;  // Whole word, pad bits included
      raw_b_q.raw <= adc_dat_b_i.raw;
    end
  end

  //////////////////////////////
  // Conversion and loopback
  //////////////////////////////

  // Pad bits dropped here through the field view
  assign conv_a = code_to_sample(raw_a_q.fld.code);
  assign conv_b = code_to_sample(raw_b_q.fld.code);

  assign adc_a_o = loop_i ? loop_a_i : conv_a;  // Loopback bypasses the register
  assign adc_b_o = loop_i ? loop_b_i : conv_b;

  // Loopback select must be a clean level once running
  a_loop_known : assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    !$isunknown(loop_i))
    else $error("adc_frontend: loop_i unknown after reset");

endmodule : adc_frontend

// ==== hdl/dac_mixer.sv ====
`timescale 1ns/1ps

module dac_mixer (
  input  rp_analog_pkg::sample_t gen_a_i,  // Generator, channel A
  input  rp_analog_pkg::sample_t gen_b_i,  // Generator, channel B
  input  rp_analog_pkg::sample_t ctl_a_i,  // Controller, channel A
  input  rp_analog_pkg::sample_t ctl_b_i,  // Controller, channel B
  output rp_analog_pkg::sample_t mix_a_o,
  output rp_analog_pkg::sample_t mix_b_o
);

  localparam int SW = rp_analog_pkg::SAMPLE_W;

  logic signed [SW:0] sum_a;  // One guard bit
  logic signed [SW:0] sum_b;

  // Clamp to 14 bits when the guard bit disagrees with the sample top bit
  function automatic rp_analog_pkg::sample_t saturate(input logic signed [SW:0] s);
    if (s[SW] != s[SW-1]) begin
      return {s[SW], {(SW-1){~s[SW]}}};  // Max or min by sign
    end
    return s[SW-1:0];
  endfunction

  //////////////////////////////
  // Sum and clamp
  //////////////////////////////

  assign sum_a = gen_a_i + ctl_a_i;  // Sign extended to SW+1
  assign sum_b = gen_b_i + ctl_b_i;

  assign mix_a_o = saturate(sum_a);
  assign mix_b_o = saturate(sum_b);

  // Clamping never flips the sign of the true sum
  always_comb begin
    a_sign_a : assert final (mix_a_o[SW-1] == sum_a[SW])
      else $error("dac_mixer: sign of mix A differs from sum");
    a_sign_b : assert final (mix_b_o[SW-1] == sum_b[SW])
      else $error("dac_mixer: sign of mix B differs from sum");
  end

endmodule : dac_mixer

// ==== hdl/moving_average.sv ====
`timescale 1ns/1ps

module moving_average #(
  parameter int DEPTH = 64  // Window length, power of two
) (
  input  logic                  adc_clk,
  input  logic                  adc_rstn,
  input  rp_analog_pkg::sample_t sample_i,  // One new sample each cycle
  output rp_analog_pkg::sample_t mean_o     // Floor of window mean
);

  localparam int SW    = rp_analog_pkg::SAMPLE_W;
  localparam int SHIFT = $clog2(DEPTH);               // Divide by DEPTH
  localparam int IDX_W = (DEPTH > 1) ? SHIFT : 1;
  localparam int SUM_W = SW + SHIFT;                  // Holds DEPTH full scale samples

  rp_analog_pkg::sample_t [DEPTH-1:0] hist_q;  // Window history
  logic [IDX_W-1:0]                   idx_q;   // Oldest slot, next to overwrite
  logic signed [SUM_W-1:0]            sum_q;   // Running window sum
  rp_analog_pkg::sample_t             old_s;   // Sample leaving the window
  logic signed [SUM_W-1:0]            sum_shr;

  assign old_s = hist_q[idx_q];

  //////////////////////////////
  // Window update
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      hist_q <= '0;  // Empty window counts as zeros
      idx_q  <= '0;
      sum_q  <= '0;
    end else begin
      hist_q[idx_q] <= sample_i;                // Replace oldest
      sum_q         <= sum_q + sample_i - old_s; // Add new, drop oldest
      if (idx_q == IDX_W'(DEPTH - 1)) begin
        idx_q <= '0;  // Wrap
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Mean
  //////////////////////////////

  // Arithmetic shift floors toward minus infinity
  assign sum_shr = sum_q >>> SHIFT;

  // Mean of 14 bit samples always fits 14 bits
  assign mean_o = sum_shr[SW-1:0];

  // Window length and index range
  a_depth_idx : assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    ((DEPTH & (DEPTH - 1)) == 0) && (idx_q < DEPTH))
    else $error("moving_average: DEPTH not a power of two or index out of range");

endmodule : moving_average

// ==== hdl/dac_encoder.sv ====
`timescale 1ns/1ps

module dac_encoder (
  input  logic                    adc_clk,
  input  logic                    adc_rstn,
  input  rp_analog_pkg::sample_t   mean_a_i,  // Window mean, channel A
  input  rp_analog_pkg::sample_t   mean_b_i,  // Window mean, channel B
  output rp_analog_pkg::dac_code_t dac_a_o,
  output rp_analog_pkg::dac_code_t dac_b_o
);

  localparam int SW = rp_analog_pkg::SAMPLE_W;

  // Zero mean in DAC coding, top bit low and the rest high
  localparam rp_analog_pkg::dac_code_t ZERO_CODE = {1'b0, {(SW-1){1'b1}}};

  // Two's complement back to negative slope offset code
  function automatic rp_analog_pkg::dac_code_t sample_to_code(
    input rp_analog_pkg::sample_t s
  );
    return {s[SW-1], ~s[SW-2:0]};
  endfunction

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_a_o <= ZERO_CODE;
      dac_b_o <= ZERO_CODE;
    end else begin
      dac_a_o <= sample_to_code(mean_a_i);
      dac_b_o <= sample_to_code(mean_b_i);
    end
  end

endmodule : dac_encoder

// ==== hdl/rp_analog_top.sv ====
`timescale 1ns/1ps

module rp_analog_top #(
  parameter int AVG_DEPTH = rp_analog_pkg::AVG_DEPTH_DEF  // Moving average window
) (
  input  logic                                 adc_clk,
  input  logic                                 adc_rstn,
  // ADC pins
  input  logic [rp_analog_pkg::ADC_WORD_W-1:0] adc_dat_a_i,
  input  logic [rp_analog_pkg::ADC_WORD_W-1:0] adc_dat_b_i,
  // Loopback level
  input  logic                                 loop_i,
  // Generator and controller samples
  input  rp_analog_pkg::sample_t                gen_a_i,
  input  rp_analog_pkg::sample_t                gen_b_i,
  input  rp_analog_pkg::sample_t                ctl_a_i,
  input  rp_analog_pkg::sample_t                ctl_b_i,
  // Converted ADC samples
  output rp_analog_pkg::sample_t                adc_a_o,
  output rp_analog_pkg::sample_t                adc_b_o,
  // DAC codes, one port per channel
  output rp_analog_pkg::dac_code_t              dac_a_o,
  output rp_analog_pkg::dac_code_t              dac_b_o
);

  rp_analog_pkg::sample_t mix_a;   // Saturated sums
  rp_analog_pkg::sample_t mix_b;
  rp_analog_pkg::sample_t mean_a;  // Window means
  rp_analog_pkg::sample_t mean_b;

  //////////////////////////////
  // ADC side
  //////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk     (adc_clk),
    .adc_rstn    (adc_rstn),
    .adc_dat_a_i (adc_dat_a_i),  // Vector into union port
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (loop_i),
    .loop_a_i    (mix_a),        // Loopback source
    .loop_b_i    (mix_b),
    .adc_a_o     (adc_a_o),
    .adc_b_o     (adc_b_o)
  );

  //////////////////////////////
  // DAC side
  //////////////////////////////

  dac_mixer u_dac_mixer (
    .gen_a_i (gen_a_i),
    .gen_b_i (gen_b_i),
    .ctl_a_i (ctl_a_i),
    .ctl_b_i (ctl_b_i),
    .mix_a_o (mix_a),
    .mix_b_o (mix_b)
  );

  moving_average #(.DEPTH (AVG_DEPTH)) avg_a (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .sample_i (mix_a),
    .mean_o   (mean_a)
  );

  moving_average #(.DEPTH (AVG_DEPTH)) avg_b (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .sample_i (mix_b),
    .mean_o   (mean_b)
  );

  dac_encoder u_dac_encoder (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .mean_a_i (mean_a),
    .mean_b_i (mean_b),
    .dac_a_o  (dac_a_o),
    .dac_b_o  (dac_b_o)
  );

endmodule : rp_analog_top

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,  // adc_clk period
  parameter int RST_CYCLES = 3    // Rising edges seen with reset low
) (
  output logic adc_clk_o,
  output logic adc_rstn_o
);

  // Free running clock, low at time zero
  initial begin
    adc_clk_o = 1'b0;
    forever #(PERIOD_NS / 2) adc_clk_o = ~adc_clk_o;
  end

  // Reset drops on a rising edge, like a synchronous reset flop
  initial begin
    adc_rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge adc_clk_o);
    adc_rstn_o <= 1'b1;
  end

endmodule : tb_clock_gen

// ==== testbench/tb_rp_analog.sv ====
`timescale 1ns/1ps

module tb_rp_analog;

  //////////////////////////////
  // Golden vector layout
  //////////////////////////////

  localparam int N_FIELDS    = 12;  // Words per vector
  localparam int N_VEC       = 22;  // Vectors in the golden file
  localparam int N_WORDS     = N_FIELDS * N_VEC;
  localparam int RST_TIMEOUT = 20;  // Cycles allowed for reset release

  localparam int F_REP       = 0;   // Hold length in cycles
  localparam int F_LOOP      = 1;
  localparam int F_ADC_A     = 2;
  localparam int F_ADC_B     = 3;
  localparam int F_GEN_A     = 4;
  localparam int F_GEN_B     = 5;
  localparam int F_CTL_A     = 6;
  localparam int F_CTL_B     = 7;
  localparam int F_EXP_ADC_A = 8;
  localparam int F_EXP_ADC_B = 9;
  localparam int F_EXP_DAC_A = 10;
  localparam int F_EXP_DAC_B = 11;

  logic adc_clk;
  logic adc_rstn;

  // DUT inputs
  logic                                 loop;
  logic [rp_analog_pkg::ADC_WORD_W-1:0] adc_dat_a;
  logic [rp_analog_pkg::ADC_WORD_W-1:0] adc_dat_b;
  rp_analog_pkg::sample_t               gen_a;
  rp_analog_pkg::sample_t               gen_b;
  rp_analog_pkg::sample_t               ctl_a;
  rp_analog_pkg::sample_t               ctl_b;

  // DUT outputs
  rp_analog_pkg::sample_t               adc_a;
  rp_analog_pkg::sample_t               adc_b;
  rp_analog_pkg::dac_code_t             dac_a;
  rp_analog_pkg::dac_code_t             dac_b;

  logic [15:0] golden_mem [0:N_WORDS-1];  // Flat copy of the vector file
  int          checks;                    // Compares done so far

  tb_clock_gen #(
    .PERIOD_NS  (40),
    .RST_CYCLES (3)
  ) u_clock_gen (
    .adc_clk_o  (adc_clk),
    .adc_rstn_o (adc_rstn)
  );

  rp_analog_top #(
    .AVG_DEPTH (rp_analog_pkg::AVG_DEPTH_DEF)
  ) dut_i (
    .adc_clk     (adc_clk),
    .adc_rstn    (adc_rstn),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .loop_i      (loop),
    .gen_a_i     (gen_a),
    .gen_b_i     (gen_b),
    .ctl_a_i     (ctl_a),
    .ctl_b_i     (ctl_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [15:0] vec_field(input int v, input int f);
    return golden_mem[v * N_FIELDS + f];
  endfunction

  // Reason and verdict, then stop
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_sample(
    input string                  name,
    input rp_analog_pkg::sample_t got,
    input rp_analog_pkg::sample_t exp
  );
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time));
    end
    checks++;
  endtask

  task automatic compare_code(
    input string                    name,
    input rp_analog_pkg::dac_code_t got,
    input rp_analog_pkg::dac_code_t exp
  );
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time));
    end
    checks++;
  endtask

  // Unfilled words stay unknown and expose a short file
  task automatic load_golden();
    for (int i = 0; i < N_WORDS; i++) begin
      golden_mem[i] = 'x;
    end
    $readmemh("testbench/rp_analog_golden.txt", golden_mem);
    for (int i = 0; i < N_WORDS; i++) begin
      if ($isunknown(golden_mem[i])) begin
        abort_run("golden file testbench/rp_analog_golden.txt is missing or too short");
      end
    end
  endtask

  // Ends on a falling edge ready to drive
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (adc_rstn !== 1'b1) begin
      if (cycles >= RST_TIMEOUT) begin
        abort_run($sformatf("reset was not released within %0d cycles", RST_TIMEOUT));
      end
      @(negedge adc_clk);
      cycles++;
    end
  endtask

  task automatic apply_vector(input int v);
    loop      = (vec_field(v, F_LOOP) != 16'h0);
    adc_dat_a = vec_field(v, F_ADC_A);
    adc_dat_b = vec_field(v, F_ADC_B);
    gen_a     = rp_analog_pkg::sample_t'(vec_field(v, F_GEN_A));  // Low 14 bits
    gen_b     = rp_analog_pkg::sample_t'(vec_field(v, F_GEN_B));
    ctl_a     = rp_analog_pkg::sample_t'(vec_field(v, F_CTL_A));
    ctl_b     = rp_analog_pkg::sample_t'(vec_field(v, F_CTL_B));
  endtask

  // ADC side every cycle and DAC codes only when asked
  task automatic check_vector(input int v, input bit with_dac);
    compare_sample("adc_a_o", adc_a, rp_analog_pkg::sample_t'(vec_field(v, F_EXP_ADC_A)));
    compare_sample("adc_b_o", adc_b, rp_analog_pkg::sample_t'(vec_field(v, F_EXP_ADC_B)));
    if (with_dac) begin
      compare_code("dac_a_o", dac_a, rp_analog_pkg::dac_code_t'(vec_field(v, F_EXP_DAC_A)));
      compare_code("dac_b_o", dac_b, rp_analog_pkg::dac_code_t'(vec_field(v, F_EXP_DAC_B)));
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int rep;
    loop      = 1'b0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    gen_a     = '0;
    gen_b     = '0;
    ctl_a     = '0;
    ctl_b     = '0;
    checks    = 0;

    load_golden();
    wait_reset_release();

    // DAC registers straight out of reset hold the zero mean code of the first vector
    compare_code("dac_a_o", dac_a, rp_analog_pkg::dac_code_t'(vec_field(0, F_EXP_DAC_A)));
    compare_code("dac_b_o", dac_b, rp_analog_pkg::dac_code_t'(vec_field(0, F_EXP_DAC_B)));

    for (int v = 0; v < N_VEC; v++) begin
      rep = int'(vec_field(v, F_REP));
      for (int r = 0; r < rep; r++) begin
        apply_vector(v);         // Falling edge drive
        @(posedge adc_clk);      // Sampled by the DUT here
        @(negedge adc_clk);      // Outputs settled half a cycle later
        check_vector(v, r == rep - 1);
      end
    end

    if (checks > 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      abort_run("no vector was checked");
    end
  end

endmodule : tb_rp_analog

// ==== testbench/rp_analog_golden.txt ====
// rep loop adc_a adc_b gen_a gen_b ctl_a ctl_b exp_adc_a exp_adc_b exp_dac_a exp_dac_b
// All hex, rep is the hold length in cycles, DAC codes are checked on the last held cycle

// ADC conversion, pad bits vary, mixes zero so DAC shows the zero mean code
01 0 0000 0000 0000 0000 0000 0000 1FFF 1FFF 1FFF 1FFF
01 0 FFFF FFFC 0000 0000 0000 0000 2000 2000 1FFF 1FFF
01 0 8000 8003 0000 0000 0000 0000 3FFF 3FFF 1FFF 1FFF
01 0 7FFC 7FFF 0000 0000 0000 0000 0000 0000 1FFF 1FFF
01 0 1235 C0DE 0000 0000 0000 0000 1B72 2FC8 1FFF 1FFF
01 0 0004 FFF8 0000 0000 0000 0000 1FFE 2001 1FFF 1FFF
03 0 4000 BFFE 0000 0000 0000 0000 0FFF 3000 1FFF 1FFF

// Step of +320 on A and -272 on B, ramp by floor(n*step/64)
01 0 0000 0000 0100 3F00 0040 3FF0 1FFF 1FFF 1FFF 1FFF
01 0 0000 0000 0100 3F00 0040 3FF0 1FFF 1FFF 1FFA 2004
01 0 0000 0000 0100 3F00 0040 3FF0 1FFF 1FFF 1FF5 2008
01 0 0000 0000 0100 3F00 0040 3FF0 1FFF 1FFF 1FF0 200C
01 0 0000 0000 0100 3F00 0040 3FF0 1FFF 1FFF 1FEB 2010

// Window full, DAC shows the exact sum
3C 0 0000 0000 0100 3F00 0040 3FF0 1FFF 1FFF 1EBF 210F
01 0 0000 0000 0100 3F00 0040 3FF0 1FFF 1FFF 1EBF 210F

// Loopback, ADC pins ignored, then saturation above max and below min
01 1 1235 C0DE 0100 3F00 0040 3FF0 0140 3EF0 1EBF 210F
01 1 1235 C0DE 1F00 2100 0200 3E00 1FFF 2000 1EBF 210F
01 1 1235 C0DE 1F00 2100 0200 3E00 1FFF 2000 1E45 218B
3F 1 1235 C0DE 1F00 2100 0200 3E00 1FFF 2000 0000 3FFF

// Overflow by one and exact boundary sums
01 1 1235 C0DE 1000 2000 1000 3FFF 1FFF 2000 0000 3FFF
01 1 1235 C0DE 1000 2001 0FFF 3FFF 1FFF 2000 0000 3FFF

// Loopback off again, one zero sample enters the window
01 0 1235 C0DE 0000 0000 0000 0000 1B72 2FC8 0000 3FFF
01 0 8000 0000 0000 0000 0000 0000 3FFF 1FFF 0080 3F7F

// ==== files.f ====
hdl/rp_analog_pkg.sv
hdl/adc_frontend.sv
hdl/dac_mixer.sv
hdl/moving_average.sv
hdl/dac_encoder.sv
hdl/rp_analog_top.sv
testbench/tb_clock_gen.sv
testbench/tb_rp_analog.sv

// ==== Bender.yml ====
package:
  name: rp_analog

sources:
  - hdl/rp_analog_pkg.sv
  - hdl/adc_frontend.sv
  - hdl/dac_mixer.sv
  - hdl/moving_average.sv
  - hdl/dac_encoder.sv
  - hdl/rp_analog_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_rp_analog.sv
